// ==== Bender.yml ====
package:
  name: dmem_subsys

sources:
  - files:
      - common/dmem_pkg.sv
      - dmem/req_capture.sv
      - dmem/dual_rr_arbiter.sv
      - dmem/reservation_unit.sv
      - dmem/dual_port_ram.sv
      - dmem/resp_router.sv
      - hdl/dmem_subsys_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_dmem_subsys.sv

// ==== common/dmem_pkg.sv ====
// data memory subsystem shared definitions
// bus widths, payload types, word indexing and the SC status code

package dmem_pkg;

    localparam int ADDR_W = 32;          // byte address
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;  // one strobe per byte

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // byte offset bits inside a word, dropped to get the word index
    localparam int WORD_LSB = $clog2(STRB_W);

    // status returned to a core by a store-conditional
    localparam data_t SC_OK   = '0;
    localparam data_t SC_FAIL = data_t'(1);

    // word index of a byte address, as used by the RAM and the same-word test
    function automatic addr_t word_of(input addr_t addr);
        return addr >> WORD_LSB;
    endfunction

endpackage

// ==== dmem/dual_port_ram.sv ====
// two-port word RAM
// byte-strobed writes on both ports, registered reads, cleared at start

`timescale 1ns/1ps

module dual_port_ram
    import dmem_pkg::*;
#(
    parameter int DEPTH = 1024
) (
    input  logic  clk_i,
    input  logic  rea_i,
    input  logic  reb_i,
    input  logic  wea_i,
    input  logic  web_i,
    input  addr_t addra_i,
    input  addr_t addrb_i,
    input  data_t wdataa_i,
    input  data_t wdatab_i,
    input  strb_t wstrba_i,
    input  strb_t wstrbb_i,
    output data_t rdataa_o,
    output data_t rdatab_o
);
    localparam int AW = $clog2(DEPTH);

    data_t         mem [DEPTH];
    logic [AW-1:0] ia, ib;

    assign ia = addra_i[WORD_LSB +: AW];
    assign ib = addrb_i[WORD_LSB +: AW];

    initial begin
        for (int k = 0; k < DEPTH; k++)
            mem[k] = '0;
    end

    always @(posedge clk_i) begin
        for (int b = 0; b < STRB_W; b++) begin
            if (wea_i && wstrba_i[b])
                mem[ia][8*b +: 8] <= wdataa_i[8*b +: 8];
            if (web_i && wstrbb_i[b])
                mem[ib][8*b +: 8] <= wdatab_i[8*b +: 8];
        end
        rdataa_o <= rea_i ? mem[ia] : '0;  // idle port returns zero
        rdatab_o <= reb_i ? mem[ib] : '0;
    end

    assert property (@(posedge clk_i) wea_i && web_i |-> ia != ib)
        else $error("both ports write word %0d", ia);

endmodule

// ==== dmem/dual_rr_arbiter.sv ====
// dual-issue round-robin arbiter
// picks up to two pending cores per round, lane b refused on the same word as lane a

`timescale 1ns/1ps

module dual_rr_arbiter
    import dmem_pkg::*;
#(
    parameter int NCORES = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [NCORES-1:0]         pend_valid_i,
    input  addr_t [NCORES-1:0]        pend_addr_i,
    output logic                      sel_valid_a_o,
    output logic                      sel_valid_b_o,
    output logic [$clog2(NCORES)-1:0] sel_core_a_o,
    output logic [$clog2(NCORES)-1:0] sel_core_b_o
);
    localparam int CW = $clog2(NCORES);

    logic [NCORES-1:0] in_flight;  // granted, waiting for capture to clear
    logic [NCORES-1:0] eligible;
    logic [NCORES-1:0] grant_mask;
    logic [CW-1:0]     rr_ptr;
    logic [CW-1:0]     core_a, core_b;
    logic              pick_a, pick_b, grant_b;

    function automatic logic [CW-1:0] wrap_inc(input logic [CW-1:0] core);
        return (core == CW'(NCORES - 1)) ? '0 : core + 1'b1;
    endfunction

    assign eligible = pend_valid_i & ~in_flight;

    // first two eligible cores, scanning from the pointer
    always_comb begin
        int idx;
        pick_a = 1'b0;
        pick_b = 1'b0;
        core_a = '0;
        core_b = '0;
        for (int j = 0; j < NCORES; j++) begin
            idx = int'(rr_ptr) + j;
            if (idx >= NCORES)
                idx = idx - NCORES;
            if (eligible[idx] && !pick_a) begin
                pick_a = 1'b1;
                core_a = CW'(idx);
            end else if (eligible[idx] && !pick_b) begin
                pick_b = 1'b1;
                core_b = CW'(idx);
            end
        end
    end

    assign grant_b = pick_b && (word_of(pend_addr_i[core_b]) != word_of(pend_addr_i[core_a]));
    assign grant_mask = (NCORES'(pick_a) << core_a) | (NCORES'(grant_b) << core_b);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sel_valid_a_o <= 1'b0;
            sel_valid_b_o <= 1'b0;
            in_flight     <= '0;
            rr_ptr        <= '0;
        end else begin
            sel_valid_a_o <= pick_a;
            sel_valid_b_o <= grant_b;
            in_flight     <= (in_flight & pend_valid_i) | grant_mask;
            if (grant_b)
                rr_ptr <= wrap_inc(core_b);  // one past the last grant
            else if (pick_a)
                rr_ptr <= wrap_inc(core_a);
        end
    end

    always_ff @(posedge clk_i) begin
        sel_core_a_o <= core_a;
        sel_core_b_o <= core_b;
    end

    // a granted core keeps its pending entry until its response returns
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sel_valid_a_o |-> pend_valid_i[sel_core_a_o])
        else $error("lane a granted core %0d with no pending request", sel_core_a_o);
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sel_valid_b_o |-> pend_valid_i[sel_core_b_o])
        else $error("lane b granted core %0d with no pending request", sel_core_b_o);

endmodule

// ==== dmem/req_capture.sv ====
// per-core request capture
// holds one load or store per core until its response is written, drives stall

`timescale 1ns/1ps

module req_capture
    import dmem_pkg::*;
#(
    parameter int NCORES = 4
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [NCORES-1:0]   re_i,
    input  logic [NCORES-1:0]   we_i,
    input  logic [NCORES-1:0]   is_lr_i,
    input  logic [NCORES-1:0]   is_sc_i,
    input  addr_t [NCORES-1:0]  addr_i,
    input  data_t [NCORES-1:0]  wdata_i,
    input  strb_t [NCORES-1:0]  wstrb_i,
    input  logic [NCORES-1:0]   resp_done_i,
    output logic [NCORES-1:0]   pend_valid_o,
    output addr_t [NCORES-1:0]  pend_addr_o,
    output logic [NCORES-1:0]   pend_we_o,
    output logic [NCORES-1:0]   pend_lr_o,
    output logic [NCORES-1:0]   pend_sc_o,
    output data_t [NCORES-1:0]  pend_wdata_o,
    output strb_t [NCORES-1:0]  pend_wstrb_o,
    output logic [NCORES-1:0]   stall_o
);
    logic [NCORES-1:0] req;

    assign req     = re_i | we_i;         // request pulse per core
    assign stall_o = req | pend_valid_o;  // stall starts in the pulse cycle

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_valid_o <= '0;
        end else begin
            for (int i = 0; i < NCORES; i++) begin
                if (req[i])
                    pend_valid_o[i] <= 1'b1;
                else if (resp_done_i[i])
                    pend_valid_o[i] <= 1'b0;  // result written, release core
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NCORES; i++) begin
            if (req[i]) begin
                pend_addr_o[i]  <= addr_i[i];
                pend_we_o[i]    <= we_i[i];
                pend_lr_o[i]    <= is_lr_i[i] & re_i[i];
                pend_sc_o[i]    <= is_sc_i[i] & we_i[i];
                pend_wdata_o[i] <= wdata_i[i];
                pend_wstrb_o[i] <= wstrb_i[i];
            end
        end
    end

    for (genvar g = 0; g < NCORES; g++) begin : gen_chk
        // a core holds off while stalled, so a pulse never lands on a live entry
        assert property (@(posedge clk_i) disable iff (!rst_n_i) req[g] |-> !pend_valid_o[g])
            else $error("core %0d pulsed while its request was pending", g);
    end

endmodule

// ==== dmem/reservation_unit.sv ====
// LR/SC reservation stage
// keeps one reservation per core, decides SC success, drives both RAM ports

`timescale 1ns/1ps

module reservation_unit
    import dmem_pkg::*;
#(
    parameter int NCORES = 4,
    parameter int DEPTH  = 1024
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      sel_valid_a_i,
    input  logic                      sel_valid_b_i,
    input  logic [$clog2(NCORES)-1:0] sel_core_a_i,
    input  logic [$clog2(NCORES)-1:0] sel_core_b_i,
    input  addr_t [NCORES-1:0]        pend_addr_i,
    input  logic [NCORES-1:0]         pend_we_i,
    input  logic [NCORES-1:0]         pend_lr_i,
    input  logic [NCORES-1:0]         pend_sc_i,
    input  data_t [NCORES-1:0]        pend_wdata_i,
    input  strb_t [NCORES-1:0]        pend_wstrb_i,
    output logic                      rea_o,
    output logic                      reb_o,
    output logic                      wea_o,
    output logic                      web_o,
    output addr_t                     addra_o,
    output addr_t                     addrb_o,
    output data_t                     wdataa_o,
    output data_t                     wdatab_o,
    output strb_t                     wstrba_o,
    output strb_t                     wstrbb_o,
    output logic                      issue_valid_a_o,
    output logic                      issue_valid_b_o,
    output logic [$clog2(NCORES)-1:0] issue_core_a_o,
    output logic [$clog2(NCORES)-1:0] issue_core_b_o,
    output logic                      issue_sc_a_o,
    output logic                      issue_sc_b_o,
    output logic                      sc_ok_a_o,
    output logic                      sc_ok_b_o
);
    logic [NCORES-1:0] rsv_valid;
    addr_t             rsv_addr [NCORES];
    addr_t             addr_a, addr_b;
    logic              ok_a, ok_b, wr_a, wr_b;

    assign addr_a = pend_addr_i[sel_core_a_i];
    assign addr_b = pend_addr_i[sel_core_b_i];

    // SC passes only on the core's own live reservation of that address
    assign ok_a = rsv_valid[sel_core_a_i] && (rsv_addr[sel_core_a_i] == addr_a);
    assign ok_b = rsv_valid[sel_core_b_i] && (rsv_addr[sel_core_b_i] == addr_b);
    assign wr_a = sel_valid_a_i && pend_we_i[sel_core_a_i] && (!pend_sc_i[sel_core_a_i] || ok_a);
    assign wr_b = sel_valid_b_i && pend_we_i[sel_core_b_i] && (!pend_sc_i[sel_core_b_i] || ok_b);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsv_valid <= '0;
        end else begin
            for (int j = 0; j < NCORES; j++) begin
                if ((wr_a && rsv_addr[j] == addr_a) || (wr_b && rsv_addr[j] == addr_b))
                    rsv_valid[j] <= 1'b0;  // any write kills reservations on it
            end
            if (sel_valid_a_i && pend_lr_i[sel_core_a_i])
                rsv_valid[sel_core_a_i] <= 1'b1;
            if (sel_valid_b_i && pend_lr_i[sel_core_b_i])
                rsv_valid[sel_core_b_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_valid_a_i && pend_lr_i[sel_core_a_i])
            rsv_addr[sel_core_a_i] <= addr_a;
        if (sel_valid_b_i && pend_lr_i[sel_core_b_i])
            rsv_addr[sel_core_b_i] <= addr_b;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            {issue_valid_a_o, issue_valid_b_o} <= '0;
            {rea_o, reb_o, wea_o, web_o}       <= '0;
        end else begin
            issue_valid_a_o <= sel_valid_a_i;
            issue_valid_b_o <= sel_valid_b_i;
            rea_o           <= sel_valid_a_i && !pend_we_i[sel_core_a_i];
            reb_o           <= sel_valid_b_i && !pend_we_i[sel_core_b_i];
            wea_o           <= wr_a;  // failed SC never writes
            web_o           <= wr_b;
        end
    end

    always_ff @(posedge clk_i) begin
        addra_o        <= addr_a;
        addrb_o        <= addr_b;
        wdataa_o       <= pend_wdata_i[sel_core_a_i];
        wdatab_o       <= pend_wdata_i[sel_core_b_i];
        wstrba_o       <= pend_wstrb_i[sel_core_a_i];
        wstrbb_o       <= pend_wstrb_i[sel_core_b_i];
        issue_core_a_o <= sel_core_a_i;
        issue_core_b_o <= sel_core_b_i;
        issue_sc_a_o   <= pend_sc_i[sel_core_a_i];
        issue_sc_b_o   <= pend_sc_i[sel_core_b_i];
        sc_ok_a_o      <= ok_a;
        sc_ok_b_o      <= ok_b;
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_a_o |-> word_of(addra_o) < DEPTH)
        else $error("lane a word index out of range: %h", addra_o);
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_b_o |-> word_of(addrb_o) < DEPTH)
        else $error("lane b word index out of range: %h", addrb_o);

endmodule

// ==== dmem/resp_router.sv ====
// response router
// aligns issue tags with RAM data and writes each core's result register

`timescale 1ns/1ps

module resp_router
    import dmem_pkg::*;
#(
    parameter int NCORES = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      issue_valid_a_i,
    input  logic                      issue_valid_b_i,
    input  logic [$clog2(NCORES)-1:0] issue_core_a_i,
    input  logic [$clog2(NCORES)-1:0] issue_core_b_i,
    input  logic                      issue_sc_a_i,
    input  logic                      issue_sc_b_i,
    input  logic                      sc_ok_a_i,
    input  logic                      sc_ok_b_i,
    input  data_t                     rdataa_i,
    input  data_t                     rdatab_i,
    output logic [NCORES-1:0]         resp_done_o,
    output data_t [NCORES-1:0]        rdata_o
);
    localparam int CW = $clog2(NCORES);

    logic          d_valid_a, d_valid_b;  // tags delayed to meet RAM read data
    logic [CW-1:0] d_core_a, d_core_b;
    logic          d_sc_a, d_sc_b, d_ok_a, d_ok_b;
    data_t         res_a, res_b;

    // plain stores see zero from the idle RAM port
    assign res_a = d_sc_a ? (d_ok_a ? SC_OK : SC_FAIL) : rdataa_i;
    assign res_b = d_sc_b ? (d_ok_b ? SC_OK : SC_FAIL) : rdatab_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            d_valid_a   <= 1'b0;
            d_valid_b   <= 1'b0;
            resp_done_o <= '0;
        end else begin
            d_valid_a   <= issue_valid_a_i;
            d_valid_b   <= issue_valid_b_i;
            resp_done_o <= (NCORES'(d_valid_a) << d_core_a) | (NCORES'(d_valid_b) << d_core_b);
        end
    end

    always_ff @(posedge clk_i) begin
        d_core_a <= issue_core_a_i;
        d_core_b <= issue_core_b_i;
        d_sc_a   <= issue_sc_a_i;
        d_sc_b   <= issue_sc_b_i;
        d_ok_a   <= sc_ok_a_i;
        d_ok_b   <= sc_ok_b_i;
        for (int i = 0; i < NCORES; i++) begin
            if (d_valid_a && d_core_a == CW'(i))
                rdata_o[i] <= res_a;
            else if (d_valid_b && d_core_b == CW'(i))
                rdata_o[i] <= res_b;  // held until the core's next response
        end
    end

endmodule

// ==== flist.f ====
+incdir+tb
common/dmem_pkg.sv
dmem/req_capture.sv
dmem/dual_rr_arbiter.sv
dmem/reservation_unit.sv
dmem/dual_port_ram.sv
dmem/resp_router.sv
hdl/dmem_subsys_top.sv
tb/tb_dmem_subsys.sv

// ==== hdl/dmem_subsys_top.sv ====
// shared data memory subsystem top level
// capture, dual round-robin arbiter, LR/SC reservation, two-port RAM, response routing

`timescale 1ns/1ps

module dmem_subsys_top
    import dmem_pkg::*;
#(
    parameter int NCORES = 4,
    parameter int DEPTH  = 1024
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [NCORES-1:0]   re_i,
    input  logic [NCORES-1:0]   we_i,
    input  logic [NCORES-1:0]   is_lr_i,
    input  logic [NCORES-1:0]   is_sc_i,
    input  addr_t [NCORES-1:0]  addr_i,
    input  data_t [NCORES-1:0]  wdata_i,
    input  strb_t [NCORES-1:0]  wstrb_i,
    output logic [NCORES-1:0]   stall_o,
    output data_t [NCORES-1:0]  rdata_o
);
    localparam int CW = $clog2(NCORES);

    logic [NCORES-1:0]  pend_valid, pend_we, pend_lr, pend_sc, resp_done;
    addr_t [NCORES-1:0] pend_addr;
    data_t [NCORES-1:0] pend_wdata;
    strb_t [NCORES-1:0] pend_wstrb;
    logic               sel_valid_a, sel_valid_b;
    logic [CW-1:0]      sel_core_a, sel_core_b;
    logic               rea, reb, wea, web;
    addr_t              addra, addrb;
    data_t              wdataa, wdatab, rdataa, rdatab;
    strb_t              wstrba, wstrbb;
    logic               issue_valid_a, issue_valid_b, issue_sc_a, issue_sc_b;
    logic [CW-1:0]      issue_core_a, issue_core_b;
    logic               sc_ok_a, sc_ok_b;

    req_capture #(.NCORES(NCORES)) u_capture (
        .clk_i, .rst_n_i, .re_i, .we_i, .is_lr_i, .is_sc_i, .addr_i, .wdata_i, .wstrb_i,
        .resp_done_i (resp_done),  .pend_valid_o(pend_valid), .pend_addr_o (pend_addr),
        .pend_we_o   (pend_we),    .pend_lr_o   (pend_lr),    .pend_sc_o   (pend_sc),
        .pend_wdata_o(pend_wdata), .pend_wstrb_o(pend_wstrb), .stall_o
    );

    dual_rr_arbiter #(.NCORES(NCORES)) u_arbiter (
        .clk_i, .rst_n_i, .pend_valid_i(pend_valid), .pend_addr_i(pend_addr),
        .sel_valid_a_o(sel_valid_a), .sel_valid_b_o(sel_valid_b),
        .sel_core_a_o (sel_core_a),  .sel_core_b_o (sel_core_b)
    );

    reservation_unit #(.NCORES(NCORES), .DEPTH(DEPTH)) u_reserve (
        .clk_i, .rst_n_i,
        .sel_valid_a_i(sel_valid_a), .sel_valid_b_i(sel_valid_b),
        .sel_core_a_i (sel_core_a),  .sel_core_b_i (sel_core_b),
        .pend_addr_i  (pend_addr),   .pend_we_i    (pend_we),    .pend_lr_i(pend_lr),
        .pend_sc_i    (pend_sc),     .pend_wdata_i (pend_wdata), .pend_wstrb_i(pend_wstrb),
        .rea_o(rea), .reb_o(reb), .wea_o(wea), .web_o(web), .addra_o(addra), .addrb_o(addrb),
        .wdataa_o(wdataa), .wdatab_o(wdatab), .wstrba_o(wstrba), .wstrbb_o(wstrbb),
        .issue_valid_a_o(issue_valid_a), .issue_valid_b_o(issue_valid_b),
        .issue_core_a_o (issue_core_a),  .issue_core_b_o (issue_core_b),
        .issue_sc_a_o   (issue_sc_a),    .issue_sc_b_o   (issue_sc_b),
        .sc_ok_a_o      (sc_ok_a),       .sc_ok_b_o      (sc_ok_b)
    );

    dual_port_ram #(.DEPTH(DEPTH)) u_ram (
        .clk_i, .rea_i(rea), .reb_i(reb), .wea_i(wea), .web_i(web),
        .addra_i (addra),  .addrb_i (addrb),  .wdataa_i(wdataa), .wdatab_i(wdatab),
        .wstrba_i(wstrba), .wstrbb_i(wstrbb), .rdataa_o(rdataa), .rdatab_o(rdatab)
    );

    resp_router #(.NCORES(NCORES)) u_router (
        .clk_i, .rst_n_i,
        .issue_valid_a_i(issue_valid_a), .issue_valid_b_i(issue_valid_b),
        .issue_core_a_i (issue_core_a),  .issue_core_b_i (issue_core_b),
        .issue_sc_a_i   (issue_sc_a),    .issue_sc_b_i   (issue_sc_b),
        .sc_ok_a_i      (sc_ok_a),       .sc_ok_b_i      (sc_ok_b),
        .rdataa_i(rdataa), .rdatab_i(rdatab), .resp_done_o(resp_done), .rdata_o
    );

endmodule

// ==== tb/tb_dmem_model.svh ====
// reference model of the shared data memory
// word array, per-core reservations, expected results of store, load, LR and SC

`ifndef TB_DMEM_MODEL_SVH
`define TB_DMEM_MODEL_SVH

data_t             model_mem [DEPTH];
logic [NCORES-1:0] model_rsv_valid;
addr_t             model_rsv_addr [NCORES];

initial begin
    for (int k = 0; k < DEPTH; k++)
        model_mem[k] = '0;  // RAM contents start at zero
    model_rsv_valid = '0;
end

function automatic int model_index(input addr_t addr);
    return int'((addr >> WORD_LSB) % DEPTH);
endfunction

function automatic data_t strobe_merge(input data_t old, input data_t wdata, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < STRB_W; b++)
        if (strb[b])
            res[8*b +: 8] = wdata[8*b +: 8];  // only strobed bytes change
    return res;
endfunction

// every write kills all reservations on its address
function automatic void model_write(input addr_t addr, input data_t wdata, input strb_t strb);
    model_mem[model_index(addr)] = strobe_merge(model_mem[model_index(addr)], wdata, strb);
    for (int c = 0; c < NCORES; c++)
        if (model_rsv_addr[c] == addr)
            model_rsv_valid[c] = 1'b0;
endfunction

function automatic data_t ref_store(input addr_t addr, input data_t wdata, input strb_t strb);
    model_write(addr, wdata, strb);
    return '0;  // plain store returns zero
endfunction

function automatic data_t ref_load(input int core, input addr_t addr, input logic lr);
    if (lr) begin
        model_rsv_valid[core] = 1'b1;
        model_rsv_addr[core]  = addr;
    end
    return model_mem[model_index(addr)];
endfunction

function automatic data_t ref_sc(input int core, input addr_t addr, input data_t wdata,
                                 input strb_t strb);
    if (!(model_rsv_valid[core] && model_rsv_addr[core] == addr))
        return SC_FAIL;  // no live reservation, no write
    model_write(addr, wdata, strb);
    return '0;
endfunction

`endif

// ==== tb/tb_dmem_subsys.sv ====
// testbench for the shared data memory subsystem
// clock, reset, per-core request tasks, result compare processes, timeout and summary

`timescale 1ns/1ps

module tb_dmem_subsys
    import dmem_pkg::*;
#(
    parameter int NCORES = 4,
    parameter int DEPTH  = 1024
);
    localparam int RST_CYCLES = 8;
    localparam int N_SEQ      = 8;  // single-core store/load pairs
    localparam int N_PAR      = 6;  // store/load pairs per core, all cores at once
    // seq + parallel + contention + lr/sc + broken reservation + sc race
    localparam int N_REQS      = 2*N_SEQ + 2*N_PAR*NCORES + NCORES + 1 + 5 + 4 + 2*NCORES + 1;
    localparam int CYCLE_LIMIT = 40*N_REQS + RST_CYCLES;
    localparam int K_DATA = 0;
    localparam int K_SC   = 1;
    localparam int K_FREE = 2;      // result recorded, checked by the test itself

    logic               clk_i = 1'b0;
    logic               rst_n_i;
    logic [NCORES-1:0]  re_i, we_i, is_lr_i, is_sc_i, stall_o;
    addr_t [NCORES-1:0] addr_i;
    data_t [NCORES-1:0] wdata_i, rdata_o;
    strb_t [NCORES-1:0] wstrb_i;

    integer             seed = 52;
    int                 cycles = 0;
    int                 data_errs = 0;
    int                 sc_errs = 0;
    int                 misc_errs = 0;
    string              test_name = "reset";
    int                 exp_kind [NCORES];
    data_t              exp_val [NCORES];
    logic [NCORES-1:0]  exp_busy = '0;
    data_t              last_result [NCORES];
    data_t              bcast_data [NCORES];

    `include "tb_dmem_model.svh"

    dmem_subsys_top #(.NCORES(NCORES), .DEPTH(DEPTH)) uut (
        .clk_i, .rst_n_i, .re_i, .we_i, .is_lr_i, .is_sc_i, .addr_i, .wdata_i, .wstrb_i,
        .stall_o, .rdata_o
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a core stall never fell", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            data_errs++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_sc(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            sc_errs++;
            $display("ERROR %s: expected SC status %h, actual %h", name, exp, act);
        end
    endtask

    // result is ready once the core's stall falls
    for (genvar g = 0; g < NCORES; g++) begin : gen_compare
        initial begin
            forever begin
                @(negedge stall_o[g]);
                if (rst_n_i) begin
                    last_result[g] = rdata_o[g];
                    if (!exp_busy[g]) begin
                        misc_errs++;
                        $display("core %0d stall fell with no request outstanding", g);
                    end else if (exp_kind[g] == K_DATA)
                        check_data(test_name, exp_val[g], rdata_o[g]);
                    else if (exp_kind[g] == K_SC)
                        check_sc(test_name, exp_val[g], rdata_o[g]);
                    exp_busy[g] = 1'b0;
                end
            end
        end
    end

    task automatic wait_idle(input int core);
        @(negedge clk_i);
        while (stall_o[core])
            @(negedge clk_i);
    endtask

    task automatic wait_all_idle();
        for (int c = 0; c < NCORES; c++)
            wait_idle(c);
    endtask

    // one-cycle request pulse, called on a falling edge
    task automatic drive_req(input int core, input logic wr, input logic amo, input addr_t addr,
                             input data_t wdata, input strb_t strb, input int kind,
                             input data_t expv);
        exp_kind[core] = kind;
        exp_val[core]  = expv;
        exp_busy[core] = 1'b1;
        re_i[core]     = !wr;
        we_i[core]     = wr;
        is_lr_i[core]  = amo & !wr;
        is_sc_i[core]  = amo & wr;
        addr_i[core]   = addr;
        wdata_i[core]  = wdata;
        wstrb_i[core]  = strb;
        @(negedge clk_i);
        re_i[core]     = 1'b0;
        we_i[core]     = 1'b0;
        is_lr_i[core]  = 1'b0;
        is_sc_i[core]  = 1'b0;
    endtask

    task automatic store_word(input int core, input addr_t addr, input data_t wdata,
                              input strb_t strb);
        data_t expv;
        wait_idle(core);
        expv = ref_store(addr, wdata, strb);
        drive_req(core, 1'b1, 1'b0, addr, wdata, strb, K_DATA, expv);
    endtask

    task automatic load_word(input int core, input addr_t addr, input logic lr);
        data_t expv;
        wait_idle(core);
        expv = ref_load(core, addr, lr);
        drive_req(core, 1'b0, lr, addr, '0, '0, K_DATA, expv);
    endtask

    task automatic cond_store(input int core, input addr_t addr, input data_t wdata,
                              input strb_t strb);
        data_t expv;
        wait_idle(core);
        expv = ref_sc(core, addr, wdata, strb);
        drive_req(core, 1'b1, 1'b1, addr, wdata, strb, K_SC, expv);
    endtask

    task automatic own_region_pairs(input int core);
        addr_t a;
        for (int n = 0; n < N_PAR; n++) begin
            a = addr_t'((256 + core*64 + {$random(seed)} % 64) << WORD_LSB);
            store_word(core, a, $random(seed), strb_t'($random(seed)));
            load_word(core, a, 1'b0);
        end
    endtask

    // all cores pulse in the same cycle on one address
    task automatic broadcast_req(input logic wr, input logic amo, input addr_t a);
        for (int c = 0; c < NCORES; c++) begin
            fork
                automatic int cc = c;
                begin
                    wait_idle(cc);
                    if (!wr)
                        drive_req(cc, 1'b0, amo, a, '0, '0, K_DATA, ref_load(cc, a, amo));
                    else
                        drive_req(cc, 1'b1, amo, a, bcast_data[cc], '1,
                                  amo ? K_FREE : K_DATA, '0);
                end
            join_none
        end
        wait fork;
    endtask

    initial begin : main_flow
        addr_t a;
        data_t seen;
        int    core;
        int    wins;
        int    winner;
        logic  found;
        rst_n_i = 1'b0;
        re_i    = '0;
        we_i    = '0;
        is_lr_i = '0;
        is_sc_i = '0;
        addr_i  = '0;
        wdata_i = '0;
        wstrb_i = '0;
        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        test_name = "store then load";
        for (int n = 0; n < N_SEQ; n++) begin
            core = {$random(seed)} % NCORES;
            a    = addr_t'(({$random(seed)} % 256) << WORD_LSB);
            store_word(core, a, $random(seed), strb_t'($random(seed)));
            load_word(core, a, 1'b0);
        end
        wait_all_idle();

        test_name = "parallel disjoint";
        for (int c = 0; c < NCORES; c++) begin
            fork
                automatic int cc = c;
                own_region_pairs(cc);
            join_none
        end
        wait fork;
        wait_all_idle();

        test_name = "same-word contention";
        a = addr_t'(600 << WORD_LSB);
        for (int c = 0; c < NCORES; c++)
            bcast_data[c] = $random(seed);
        broadcast_req(1'b1, 1'b0, a);
        wait_all_idle();
        wait_idle(0);
        drive_req(0, 1'b0, 1'b0, a, '0, '0, K_FREE, '0);
        wait_all_idle();
        seen  = last_result[0];
        found = 1'b0;
        for (int c = 0; c < NCORES; c++)
            if (seen === bcast_data[c])
                found = 1'b1;
        if (!found) begin
            misc_errs++;
            $display("ERROR %s: expected one of the stored words, actual %h", test_name, seen);
        end

        test_name = "lr then sc";
        a = addr_t'(700 << WORD_LSB);
        load_word(NCORES - 1, a, 1'b1);
        cond_store(NCORES - 1, a, $random(seed), '1);
        load_word(NCORES - 1, a, 1'b0);
        cond_store(NCORES - 1, a, $random(seed), '1);  // reservation already used
        load_word(NCORES - 1, a, 1'b0);
        wait_all_idle();

        test_name = "store breaks reservation";
        a = addr_t'(710 << WORD_LSB);
        load_word(0, a, 1'b1);
        wait_idle(0);
        store_word(1, a, $random(seed), '1);
        wait_idle(1);
        cond_store(0, a, $random(seed), '1);
        load_word(0, a, 1'b0);
        wait_all_idle();

        test_name = "sc race";
        a = addr_t'(720 << WORD_LSB);
        for (int c = 0; c < NCORES; c++)
            bcast_data[c] = $random(seed);
        broadcast_req(1'b0, 1'b1, a);
        wait_all_idle();
        broadcast_req(1'b1, 1'b1, a);
        wait_all_idle();
        wins   = 0;
        winner = 0;
        for (int c = 0; c < NCORES; c++) begin
            if (last_result[c] === '0) begin
                wins++;
                winner = c;
            end else
                check_sc(test_name, SC_FAIL, last_result[c]);
        end
        if (wins != 1) begin
            misc_errs++;
            $display("ERROR %s: expected 1 successful store-conditional, actual %0d",
                     test_name, wins);
        end
        model_write(a, bcast_data[winner], '1);
        load_word(0, a, 1'b0);
        wait_all_idle();

        $display("error counts: data %0d, sc %0d, other %0d", data_errs, sc_errs, misc_errs);
        if (data_errs + sc_errs + misc_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
